// File: common/qs_params.svh
`ifndef QS_PARAMS_SVH
`define QS_PARAMS_SVH

`define QS_DATA_W          32
`define QS_ADDR_W          23
`define QS_NUM_ELEMS       10
`define QS_ADDR_STEP       4    // bytes per sdram word

// wishbone offsets within the low address byte
`define QS_REG_STATUS      8'h00
`define QS_REG_BASE        8'h04
`define QS_REG_RESULT0     8'h0C
`define QS_REG_RESULT9     8'h30

`define QS_STATUS_IDLE_BIT 2
`define QS_STATUS_DONE_BIT 1

`define QS_BASE_RESET      23'h000000

`endif

// File: common/qs_pkg.sv
`include "qs_params.svh"

package qs_pkg;

    typedef logic signed [`QS_DATA_W-1:0] qs_data_t;
    typedef logic [`QS_ADDR_W-1:0]        sdram_addr_t;
    typedef logic [3:0]                   elem_idx_t;

    // register map with results at a 4 byte stride
    typedef enum logic [7:0] {
        REG_STATUS  = `QS_REG_STATUS,
        REG_BASE    = `QS_REG_BASE,
        REG_RESULT0 = `QS_REG_RESULT0,
        REG_RESULT1 = 8'h10,
        REG_RESULT2 = 8'h14,
        REG_RESULT3 = 8'h18,
        REG_RESULT4 = 8'h1C,
        REG_RESULT5 = 8'h20,
        REG_RESULT6 = 8'h24,
        REG_RESULT7 = 8'h28,
        REG_RESULT8 = 8'h2C,
        REG_RESULT9 = `QS_REG_RESULT9
    } reg_addr_e;

    typedef enum logic [1:0] {CTRL_IDLE, CTRL_ARMED, CTRL_BUSY, CTRL_DONE} ctrl_state_e;

    typedef enum logic [1:0] {FETCH_IDLE, FETCH_REQ, FETCH_WAIT_EMPTY, FETCH_DONE} fetch_state_e;

    typedef enum logic [1:0] {SORT_LOAD, SORT_DRAIN, SORT_DONE} sort_state_e;

endpackage

// File: hw/wb_regs.sv
`timescale 1ns/1ps
`include "qs_params.svh"

module wb_regs (
    input  logic                wb_clk_i,
    input  logic                wb_rst_i,

    input  logic                wbs_stb_i,
    input  logic                wbs_cyc_i,
    input  logic                wbs_we_i,
    input  logic [3:0]          wbs_sel_i,
    input  logic [31:0]         wbs_adr_i,
    input  logic [31:0]         wbs_dat_i,
    output logic                wbs_ack_o,
    output logic [31:0]         wbs_dat_o,

    output logic                run_start_o,
    output qs_pkg::sdram_addr_t base_addr_o,

    input  logic                res_valid_i,
    input  qs_pkg::qs_data_t    res_data_i,
    output logic                res_ready_o
);
    import qs_pkg::*;

    ctrl_state_e state;
    logic        wb_req;
    logic        wb_wr;
    logic [7:0]  adr_lo;
    logic [7:0]  res_off;
    logic        res_hit;
    elem_idx_t   res_idx;
    logic [31:0] rd_data;
    sdram_addr_t base_wdata;
    logic        start_wr;
    logic        res_xfer;
    elem_idx_t   res_cnt;
    qs_data_t    res_buf [`QS_NUM_ELEMS];

    assign wb_req = wbs_stb_i && wbs_cyc_i && !wbs_ack_o;  // stb still high during ack
    assign wb_wr  = wb_req && wbs_we_i;
    assign adr_lo = wbs_adr_i[7:0];

    assign res_off = adr_lo - REG_RESULT0;
    assign res_idx = res_off[5:2];
    assign res_hit = (adr_lo >= REG_RESULT0) && (adr_lo <= REG_RESULT9)
                     && (adr_lo[1:0] == 2'b00);

    // byte lanes 0..2 carry the 23 bit address
    assign base_wdata = {wbs_sel_i[2] ? wbs_dat_i[22:16] : base_addr_o[22:16],
                         wbs_sel_i[1] ? wbs_dat_i[15:8]  : base_addr_o[15:8],
                         wbs_sel_i[0] ? wbs_dat_i[7:0]   : base_addr_o[7:0]};

    assign start_wr = wb_wr && (adr_lo == REG_STATUS) && wbs_sel_i[0] && wbs_dat_i[0];

    assign res_ready_o = (state == CTRL_BUSY);
    assign res_xfer    = res_valid_i && res_ready_o;

    always_comb begin
        rd_data = '0;
        if (adr_lo == REG_STATUS) begin
            case (state)
                CTRL_IDLE, CTRL_ARMED: rd_data[`QS_STATUS_IDLE_BIT] = 1'b1;
                CTRL_DONE:             rd_data[`QS_STATUS_DONE_BIT] = 1'b1;
                default:               rd_data = '0;  // busy reads as zero
            endcase
        end else if (adr_lo == REG_BASE) begin
            rd_data = 32'(base_addr_o);
        end else if (res_hit && state == CTRL_DONE) begin
            rd_data = res_buf[res_idx];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state       <= CTRL_IDLE;
            wbs_ack_o   <= 1'b0;
            run_start_o <= 1'b0;
            res_cnt     <= '0;
            base_addr_o <= `QS_BASE_RESET;
        end else begin
            wbs_ack_o   <= wb_req;
            run_start_o <= 1'b0;
            case (state)
                CTRL_IDLE, CTRL_ARMED: begin
                    if (wb_wr && adr_lo == REG_BASE) begin
                        base_addr_o <= base_wdata;
                        state       <= CTRL_ARMED;
                    end else if (start_wr && state == CTRL_ARMED) begin
                        run_start_o <= 1'b1;
                        res_cnt     <= '0;
                        state       <= CTRL_BUSY;
                    end
                end
                CTRL_BUSY: begin
                    if (res_xfer) begin
                        res_cnt <= res_cnt + 1'b1;
                        if (res_cnt == elem_idx_t'(`QS_NUM_ELEMS - 1))
                            state <= CTRL_DONE;
                    end
                end
                CTRL_DONE: state <= CTRL_DONE;  // held until reset
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_req && !wbs_we_i)
            wbs_dat_o <= rd_data;
        if (res_xfer) begin  // oldest result ends up in entry 0
            for (int i = 0; i < `QS_NUM_ELEMS - 1; i++)
                res_buf[i] <= res_buf[i+1];
            res_buf[`QS_NUM_ELEMS-1] <= res_data_i;
        end
    end

endmodule

// File: dma/sdram_fetch.sv
`timescale 1ns/1ps
`include "qs_params.svh"

module sdram_fetch (
    input  logic                  wb_clk_i,
    input  logic                  wb_rst_i,

    input  logic                  run_start_i,
    input  qs_pkg::sdram_addr_t   base_addr_i,

    output qs_pkg::sdram_addr_t   sdram_addr_o,
    output logic                  sdram_req_valid_o,
    input  logic                  sdram_busy_i,
    input  logic [`QS_DATA_W-1:0] sdram_rdata_i,
    input  logic                  sdram_rdata_valid_i,

    output logic                  elem_valid_o,
    output qs_pkg::qs_data_t      elem_data_o,
    input  logic                  elem_ready_i
);
    import qs_pkg::*;

    fetch_state_e state;
    elem_idx_t    word_cnt;
    logic         buf_free;
    logic         rd_ret;

    // buffer empty now or drained at this edge
    assign buf_free = !elem_valid_o || elem_ready_i;
    assign rd_ret   = (state == FETCH_REQ) && sdram_rdata_valid_i;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state             <= FETCH_IDLE;
            sdram_req_valid_o <= 1'b0;
            elem_valid_o      <= 1'b0;
            word_cnt          <= '0;
        end else begin
            if (elem_valid_o && elem_ready_i)
                elem_valid_o <= 1'b0;

            case (state)
                FETCH_IDLE: begin
                    if (run_start_i) begin
                        sdram_req_valid_o <= 1'b1;
                        word_cnt          <= '0;
                        state             <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    // request taken once busy is low
                    if (sdram_req_valid_o && !sdram_busy_i)
                        sdram_req_valid_o <= 1'b0;
                    if (sdram_rdata_valid_i) begin
                        elem_valid_o <= 1'b1;
                        word_cnt     <= word_cnt + 1'b1;
                        if (word_cnt == elem_idx_t'(`QS_NUM_ELEMS - 1))
                            state <= FETCH_DONE;
                        else
                            state <= FETCH_WAIT_EMPTY;
                    end
                end
                FETCH_WAIT_EMPTY: begin
                    if (buf_free) begin
                        sdram_req_valid_o <= 1'b1;
                        state             <= FETCH_REQ;
                    end
                end
                FETCH_DONE: state <= FETCH_DONE;  // last word may still drain
            endcase
        end
    end

    // address and prefetch word
    always_ff @(posedge wb_clk_i) begin
        if (state == FETCH_IDLE && run_start_i)
            sdram_addr_o <= base_addr_i;
        else if (rd_ret)
            sdram_addr_o <= sdram_addr_o + sdram_addr_t'(`QS_ADDR_STEP);

        if (rd_ret)
            elem_data_o <= sdram_rdata_i;
    end

endmodule

// File: sorter/qs_sorter.sv
`timescale 1ns/1ps
`include "qs_params.svh"

module qs_sorter (
    input  logic             wb_clk_i,
    input  logic             wb_rst_i,

    input  logic             run_start_i,

    input  logic             in_valid_i,
    input  qs_pkg::qs_data_t in_data_i,
    output logic             in_ready_o,

    output logic             out_valid_o,
    output qs_pkg::qs_data_t out_data_o,
    input  logic             out_ready_i
);
    import qs_pkg::*;

    sort_state_e              state;
    elem_idx_t                load_cnt;
    elem_idx_t                out_idx;
    logic                     in_xfer;
    logic                     out_xfer;
    logic [`QS_NUM_ELEMS-1:0] gt;
    qs_data_t                 arr     [`QS_NUM_ELEMS];
    qs_data_t                 ins_arr [`QS_NUM_ELEMS];

    assign in_ready_o  = (state == SORT_LOAD);
    assign in_xfer     = in_valid_i && in_ready_o;
    assign out_valid_o = (state == SORT_DRAIN);
    assign out_xfer    = out_valid_o && out_ready_i;
    assign out_data_o  = arr[out_idx];

    // one-cycle insertion moves entries above the new word up by one
    always_comb begin
        for (int i = 0; i < `QS_NUM_ELEMS; i++)
            gt[i] = (elem_idx_t'(i) < load_cnt) && (arr[i] > in_data_i);

        if (gt[0] || load_cnt == '0)
            ins_arr[0] = in_data_i;
        else
            ins_arr[0] = arr[0];

        for (int i = 1; i < `QS_NUM_ELEMS; i++) begin
            if (gt[i-1])
                ins_arr[i] = arr[i-1];
            else if (gt[i] || load_cnt == elem_idx_t'(i))
                ins_arr[i] = in_data_i;  // first slot above all smaller or equal
            else
                ins_arr[i] = arr[i];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state    <= SORT_DONE;  // waits for a start
            load_cnt <= '0;
            out_idx  <= '0;
        end else if (run_start_i) begin
            state    <= SORT_LOAD;
            load_cnt <= '0;
        end else begin
            case (state)
                SORT_LOAD: begin
                    if (in_xfer) begin
                        load_cnt <= load_cnt + 1'b1;
                        if (load_cnt == elem_idx_t'(`QS_NUM_ELEMS - 1)) begin
                            state   <= SORT_DRAIN;
                            out_idx <= '0;
                        end
                    end
                end
                SORT_DRAIN: begin
                    if (out_xfer) begin
                        out_idx <= out_idx + 1'b1;
                        if (out_idx == elem_idx_t'(`QS_NUM_ELEMS - 1))
                            state <= SORT_DONE;
                    end
                end
                SORT_DONE: state <= SORT_DONE;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (in_xfer) begin
            for (int i = 0; i < `QS_NUM_ELEMS; i++)
                arr[i] <= ins_arr[i];
        end
    end

endmodule

// File: hw/qs_dma_top.sv
`timescale 1ns/1ps
`include "qs_params.svh"

module qs_dma_top (
    input  logic                    wb_clk_i,
    input  logic                    wb_rst_i,

    // wishbone slave
    input  logic                    wbs_stb_i,
    input  logic                    wbs_cyc_i,
    input  logic                    wbs_we_i,
    input  logic [3:0]              wbs_sel_i,
    input  logic [31:0]             wbs_adr_i,
    input  logic [31:0]             wbs_dat_i,
    output logic                    wbs_ack_o,
    output logic [31:0]             wbs_dat_o,

    // sdram controller read port
    output qs_pkg::sdram_addr_t     sdram_addr_o,
    output logic                    sdram_req_valid_o,
    input  logic                    sdram_busy_i,
    input  logic [`QS_DATA_W-1:0]   sdram_rdata_i,
    input  logic                    sdram_rdata_valid_i
);
    import qs_pkg::*;

    logic        run_start;
    sdram_addr_t base_addr;

    logic        in_valid;     // fetcher -> sorter
    qs_data_t    in_data;
    logic        in_ready;

    logic        out_valid;    // sorter -> result buffer
    qs_data_t    out_data;
    logic        out_ready;

    wb_regs wb_regs_i (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .wbs_stb_i   (wbs_stb_i),
        .wbs_cyc_i   (wbs_cyc_i),
        .wbs_we_i    (wbs_we_i),
        .wbs_sel_i   (wbs_sel_i),
        .wbs_adr_i   (wbs_adr_i),
        .wbs_dat_i   (wbs_dat_i),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_dat_o   (wbs_dat_o),
        .run_start_o (run_start),
        .base_addr_o (base_addr),
        .res_valid_i (out_valid),
        .res_data_i  (out_data),
        .res_ready_o (out_ready)
    );

    sdram_fetch sdram_fetch_i (
        .wb_clk_i            (wb_clk_i),
        .wb_rst_i            (wb_rst_i),
        .run_start_i         (run_start),
        .base_addr_i         (base_addr),
        .sdram_addr_o        (sdram_addr_o),
        .sdram_req_valid_o   (sdram_req_valid_o),
        .sdram_busy_i        (sdram_busy_i),
        .sdram_rdata_i       (sdram_rdata_i),
        .sdram_rdata_valid_i (sdram_rdata_valid_i),
        .elem_valid_o        (in_valid),
        .elem_data_o         (in_data),
        .elem_ready_i        (in_ready)
    );

    qs_sorter qs_sorter_i (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .run_start_i (run_start),
        .in_valid_i  (in_valid),
        .in_data_i   (in_data),
        .in_ready_o  (in_ready),
        .out_valid_o (out_valid),
        .out_data_o  (out_data),
        .out_ready_i (out_ready)
    );

endmodule

// File: verif/tb_sdram_model.sv
`timescale 1ns/1ps
`include "qs_params.svh"

module tb_sdram_model (
    input  logic                  wb_clk_i,
    input  logic                  wb_rst_i,

    input  qs_pkg::sdram_addr_t   addr_i,
    input  logic                  req_valid_i,
    output logic                  busy_o,
    output logic [`QS_DATA_W-1:0] rdata_o,
    output logic                  rdata_valid_o,

    // backdoor fill from the testbench
    input  logic                  fill_en_i,
    input  qs_pkg::sdram_addr_t   fill_addr_i,
    input  logic [`QS_DATA_W-1:0] fill_data_i
);
    import qs_pkg::*;

    logic [`QS_DATA_W-1:0] mem [sdram_addr_t];
    logic                  pending;
    int unsigned           delay;
    sdram_addr_t           rd_addr;

    // unfilled locations read a pattern of the whole address
    function automatic logic [`QS_DATA_W-1:0] read_word(input sdram_addr_t a);
        if (mem.exists(a))
            return mem[a];
        return {a, 9'h0} ^ {9'h0, a} ^ 32'hc3a5_0f1e;
    endfunction

    always @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            busy_o        <= 1'b0;
            rdata_o       <= '0;
            rdata_valid_o <= 1'b0;
            pending       <= 1'b0;
            delay         <= 0;
        end else begin
            rdata_valid_o <= 1'b0;
            busy_o        <= ($urandom_range(3) == 0);  // about one cycle in four
            if (fill_en_i)
                mem[fill_addr_i] = fill_data_i;
            if (pending) begin
                if (delay == 0) begin
                    rdata_o       <= read_word(rd_addr);
                    rdata_valid_o <= 1'b1;
                    pending       <= 1'b0;
                end else begin
                    delay <= delay - 1;
                end
            end else if (req_valid_i && !busy_o) begin
                pending <= 1'b1;
                rd_addr <= addr_i;
                delay   <= $urandom_range(5, 0);  // data 1 to 6 cycles later
            end
        end
    end

endmodule

// File: verif/tb_qs_dma.sv
`timescale 1ns/1ps
`include "qs_params.svh"

module tb_qs_dma;
    import qs_pkg::*;

    logic                  wb_clk_i;
    logic                  wb_rst_i;
    logic                  wbs_stb_i;
    logic                  wbs_cyc_i;
    logic                  wbs_we_i;
    logic [3:0]            wbs_sel_i;
    logic [31:0]           wbs_adr_i;
    logic [31:0]           wbs_dat_i;
    logic                  wbs_ack_o;
    logic [31:0]           wbs_dat_o;
    sdram_addr_t           sdram_addr_o;
    logic                  sdram_req_valid_o;
    logic                  sdram_busy_i;
    logic [`QS_DATA_W-1:0] sdram_rdata_i;
    logic                  sdram_rdata_valid_i;
    logic                  fill_en;
    sdram_addr_t           fill_addr;
    logic [`QS_DATA_W-1:0] fill_data;

    int          err_cnt;
    int          check_cnt;
    int          test_cnt;
    int          test_err_base;
    int unsigned seed_val;
    sdram_addr_t req_log [$];
    qs_data_t    ref_data [$];
    qs_data_t    exp_sorted [`QS_NUM_ELEMS];

    qs_dma_top qs_dma_top_i (
        .wb_clk_i            (wb_clk_i),
        .wb_rst_i            (wb_rst_i),
        .wbs_stb_i           (wbs_stb_i),
        .wbs_cyc_i           (wbs_cyc_i),
        .wbs_we_i            (wbs_we_i),
        .wbs_sel_i           (wbs_sel_i),
        .wbs_adr_i           (wbs_adr_i),
        .wbs_dat_i           (wbs_dat_i),
        .wbs_ack_o           (wbs_ack_o),
        .wbs_dat_o           (wbs_dat_o),
        .sdram_addr_o        (sdram_addr_o),
        .sdram_req_valid_o   (sdram_req_valid_o),
        .sdram_busy_i        (sdram_busy_i),
        .sdram_rdata_i       (sdram_rdata_i),
        .sdram_rdata_valid_i (sdram_rdata_valid_i)
    );

    tb_sdram_model sdram_model_i (
        .wb_clk_i      (wb_clk_i),
        .wb_rst_i      (wb_rst_i),
        .addr_i        (sdram_addr_o),
        .req_valid_i   (sdram_req_valid_o),
        .busy_o        (sdram_busy_i),
        .rdata_o       (sdram_rdata_i),
        .rdata_valid_o (sdram_rdata_valid_i),
        .fill_en_i     (fill_en),
        .fill_addr_i   (fill_addr),
        .fill_data_i   (fill_data)
    );

    always #5 wb_clk_i = ~wb_clk_i;

    // requests taken by the controller
    always @(posedge wb_clk_i) begin
        if (!wb_rst_i && sdram_req_valid_o && !sdram_busy_i)
            req_log.push_back(sdram_addr_o);
    end

    task automatic check_data(input string name, input qs_data_t got, input qs_data_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %0t %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input sdram_addr_t got,
                              input sdram_addr_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %0t %s got %06h expected %06h", $time, name, got, exp);
        end
    endtask

    task automatic wb_cycle(input logic we, input logic [7:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        int n;
        @(posedge wb_clk_i);
        wbs_stb_i <= 1'b1;
        wbs_cyc_i <= 1'b1;
        wbs_we_i  <= we;
        wbs_sel_i <= 4'hF;
        wbs_adr_i <= {24'h0, adr};
        wbs_dat_i <= wdata;
        n = 0;
        do begin
            @(posedge wb_clk_i);
            n++;
        end while (!wbs_ack_o && n < 20);
        rdata = wbs_dat_o;
        wbs_stb_i <= 1'b0;
        wbs_cyc_i <= 1'b0;
        wbs_we_i  <= 1'b0;
        check_cnt++;
        if (!wbs_ack_o) begin
            err_cnt++;
            $display("no ack for offset %02h within 20 cycles", adr);
        end else if (n != 2) begin  // ack one cycle after the request is sampled
            err_cnt++;
            $display("ack for offset %02h came %0d cycles after the request", adr, n);
        end
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] data);
        wb_cycle(1'b0, adr, 32'h0, data);
    endtask

    task automatic apply_reset();
        @(posedge wb_clk_i);
        wb_rst_i <= 1'b1;
        repeat (8) @(posedge wb_clk_i);
        wb_rst_i <= 1'b0;
        req_log.delete();
    endtask

    task automatic end_test(input string desc);
        test_cnt++;
        if (err_cnt == test_err_base)
            $display("test %0d %s: ok", test_cnt, desc);
        else
            $display("test %0d %s: %0d errors", test_cnt, desc, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // ten words with at least one negative and one duplicate
    task automatic load_memory(input sdram_addr_t base);
        qs_data_t w;
        ref_data.delete();
        for (int i = 0; i < `QS_NUM_ELEMS; i++) begin
            if (i == 0)
                w = qs_data_t'($urandom | 32'h8000_0000);
            else if (i == 5)
                w = ref_data[2];
            else if ($urandom_range(1) == 1)
                w = qs_data_t'($urandom_range(6)) - 3;  // small values make dups likely
            else
                w = qs_data_t'($urandom);
            ref_data.push_back(w);
            @(posedge wb_clk_i);
            fill_en   <= 1'b1;
            fill_addr <= base + sdram_addr_t'(4 * i);
            fill_data <= w;
        end
        @(posedge wb_clk_i);
        fill_en <= 1'b0;
    endtask

    // reference bubble sort in ascending signed order
    task automatic build_expected();
        qs_data_t t;
        for (int i = 0; i < `QS_NUM_ELEMS; i++)
            exp_sorted[i] = ref_data[i];
        for (int i = 0; i < `QS_NUM_ELEMS - 1; i++) begin
            for (int j = 0; j < `QS_NUM_ELEMS - 1 - i; j++) begin
                if (exp_sorted[j] > exp_sorted[j+1]) begin
                    t               = exp_sorted[j];
                    exp_sorted[j]   = exp_sorted[j+1];
                    exp_sorted[j+1] = t;
                end
            end
        end
    endtask

    task automatic run_sequence(input string tag);
        sdram_addr_t base;
        logic [31:0] rd;
        int          polls;
        logic        done;
        base = sdram_addr_t'($urandom_range(23'h7ff000)) & ~sdram_addr_t'(3);
        load_memory(base);
        build_expected();
        req_log.delete();

        wb_write(REG_BASE, 32'(base));
        wb_read(REG_BASE, rd);
        check_addr("wbs_dat_o base", rd[`QS_ADDR_W-1:0], base);
        wb_read(REG_STATUS, rd);
        check_status("wbs_dat_o status armed", rd, 32'(1) << `QS_STATUS_IDLE_BIT);
        wb_write(REG_STATUS, 32'h1);

        polls = 0;
        done  = 1'b0;
        while (!done && polls < 2000) begin
            wb_read(REG_STATUS, rd);
            polls++;
            if (rd[`QS_STATUS_DONE_BIT])
                done = 1'b1;
            else
                check_status("wbs_dat_o status busy", rd, 32'h0);
        end
        check_cnt++;
        if (!done) begin
            err_cnt++;
            $display("timeout: done bit not seen after %0d status reads", polls);
        end else begin
            check_status("wbs_dat_o status done", rd, 32'(1) << `QS_STATUS_DONE_BIT);
        end
        end_test({tag, " status polling"});

        check_cnt++;
        if (req_log.size() != `QS_NUM_ELEMS) begin
            err_cnt++;
            $display("expected %0d SDRAM requests but saw %0d", `QS_NUM_ELEMS, req_log.size());
        end
        for (int k = 0; k < req_log.size() && k < `QS_NUM_ELEMS; k++)
            check_addr($sformatf("sdram_addr_o req%0d", k), req_log[k],
                       base + sdram_addr_t'(4 * k));
        end_test({tag, " sdram request addresses"});

        for (int k = 0; k < `QS_NUM_ELEMS; k++) begin
            wb_read(8'(REG_RESULT0 + 4 * k), rd);
            check_data($sformatf("wbs_dat_o result%0d", k), qs_data_t'(rd), exp_sorted[k]);
        end
        end_test({tag, " sorted results"});
    endtask

    initial begin
        logic [31:0] rd;
        seed_val      = $urandom(32'h6ca7_4732);
        err_cnt       = 0;
        check_cnt     = 0;
        test_cnt      = 0;
        test_err_base = 0;
        wb_clk_i      = 1'b0;
        wb_rst_i      = 1'b1;
        wbs_stb_i     = 1'b0;
        wbs_cyc_i     = 1'b0;
        wbs_we_i      = 1'b0;
        wbs_sel_i     = 4'h0;
        wbs_adr_i     = 32'h0;
        wbs_dat_i     = 32'h0;
        fill_en       = 1'b0;
        fill_addr     = '0;
        fill_data     = '0;

        apply_reset();
        wb_read(REG_STATUS, rd);
        check_status("wbs_dat_o status", rd, 32'(1) << `QS_STATUS_IDLE_BIT);
        wb_read(8'h08, rd);
        check_status("wbs_dat_o offset 08", rd, 32'h0);
        wb_read(8'h40, rd);
        check_status("wbs_dat_o offset 40", rd, 32'h0);
        end_test("reset status and unmapped reads");

        // start without a base address
        wb_write(REG_STATUS, 32'h1);
        wb_read(REG_STATUS, rd);
        check_status("wbs_dat_o status", rd, 32'(1) << `QS_STATUS_IDLE_BIT);
        repeat (30) @(posedge wb_clk_i);
        check_cnt++;
        if (req_log.size() != 0) begin
            err_cnt++;
            $display("SDRAM request issued after a start with no base write");
        end
        end_test("start before base ignored");

        run_sequence("first run");

        apply_reset();
        run_sequence("rerun");

        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // whole-run limit
    initial begin
        repeat (200000) @(posedge wb_clk_i);
        $display("simulation limit of 200000 cycles reached");
        $display("Test failed");
        $finish;
    end

endmodule

// File: all.f
+incdir+common
common/qs_pkg.sv
hw/wb_regs.sv
dma/sdram_fetch.sv
sorter/qs_sorter.sv
hw/qs_dma_top.sv
verif/tb_sdram_model.sv
verif/tb_qs_dma.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it, then searches the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_qs_dma -o tb_qs_dma -f all.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build returned an error"
    exit 1
fi

./obj_dir/tb_qs_dma > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation returned status $sim_status"
    exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "Test passed" "$SIM_LOG"; then
    echo "no pass message in $SIM_LOG"
    exit 1
fi
exit 0
